/* verilog/serialPkg.sv */
package serialPkg;

	// clocks per oversample tick
	localparam int CLOCKS_PER_SAMPLE = 4;

	// oversample ticks per bit, so one bit is 32 clocks
	localparam int SAMPLES_PER_BIT = 8;

	// start bit, 8 data bits, stop bit
	localparam int FRAME_BITS = 10;

	// one character on the line
	typedef logic [7:0] charByte;

	// counter types sized from the rates above
	typedef logic [$clog2(CLOCKS_PER_SAMPLE)-1:0] clockIndex;
	typedef logic [$clog2(SAMPLES_PER_BIT)-1:0] sampleIndex;

	// receiver output
	// valid is a one-clock pulse, data holds until the next frame shifts in
	typedef struct packed {
		charByte data;
		logic valid;
	} rxChar;

endpackage

/* verilog/gamePkg.sv */
package gamePkg;

	// clocks per slow game tick
	localparam int CLOCKS_PER_GAME_TICK = 64;

	// random source, never zero
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	// x^16 + x^14 + x^13 + x^11 + 1
	// bit 15 is x^16, shift left, feedback into bit 0
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	// host command bytes
	// 'T' gets 4 timer bytes, msb first
	localparam logic [7:0] CMD_TIME = 8'h54;
	// 'R' gets 2 lfsr bytes, msb first
	localparam logic [7:0] CMD_RANDOM = 8'h52;
	// 'C' clears the timer, echoed back as the reply
	localparam logic [7:0] CMD_CLEAR = 8'h43;

	// game tick divider counter
	typedef logic [$clog2(CLOCKS_PER_GAME_TICK)-1:0] tickIndex;

	// timebase level, 48 bits
	typedef struct packed {
		logic [31:0] gameTime;
		logic [15:0] randomValue;
	} timebaseSnap;

endpackage

/* verilog/baudTicker.sv */
`timescale 1ns/1ps

module baudTicker (
	input logic clock,
	input logic rst,
	output logic sampleTick,
	output logic bitTick
);

	// clocks within one sample period
	serialPkg::clockIndex clockCount;
	// samples within one bit period
	serialPkg::sampleIndex sampleCount;

	always_ff @(posedge clock) begin
		if (rst) begin
			clockCount <= '0;
			sampleCount <= '0;
			sampleTick <= 1'b0;
			bitTick <= 1'b0;
		end else begin
			// enables are single-cycle
			sampleTick <= 1'b0;
			bitTick <= 1'b0;
			if (clockCount == serialPkg::clockIndex'(serialPkg::CLOCKS_PER_SAMPLE - 1)) begin
				clockCount <= '0;
				sampleTick <= 1'b1;
				// bit tick lands on the last sample of each bit
				if (sampleCount == serialPkg::sampleIndex'(serialPkg::SAMPLES_PER_BIT - 1)) begin
					sampleCount <= '0;
					bitTick <= 1'b1;
				end else begin
					sampleCount <= sampleCount + 1'b1;
				end
			end else begin
				clockCount <= clockCount + 1'b1;
			end
		end
	end

endmodule

/* verilog/serialReceiver.sv */
`timescale 1ns/1ps

module serialReceiver (
	input logic clock,
	input logic rst,
	input logic sampleTick,
	input logic serialIn,
	output serialPkg::rxChar rxChar
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rxState;

	rxState state;
	// two-flop synchronizer, rxSync[1] is the safe copy
	logic [1:0] rxSync;
	logic rxLine;
	serialPkg::sampleIndex sampleCount;
	logic [2:0] bitCount;
	serialPkg::charByte shiftReg;
	logic charValid;

	assign rxLine = rxSync[1];

	// line idles high
	always_ff @(posedge clock) begin
		if (rst) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], serialIn};
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= RX_IDLE;
			sampleCount <= '0;
			bitCount <= '0;
			charValid <= 1'b0;
		end else begin
			charValid <= 1'b0;
			if (sampleTick) begin
				case (state)
					RX_IDLE: begin
						// first low sample marks the start edge
						if (!rxLine) begin
							state <= RX_START;
							sampleCount <= '0;
						end
					end
					RX_START: begin
						// four samples in is mid start bit
						if (sampleCount == serialPkg::sampleIndex'(serialPkg::SAMPLES_PER_BIT / 2 - 1)) begin
							sampleCount <= '0;
							bitCount <= '0;
							// glitch if the line went back high
							state <= rxLine ? RX_IDLE : RX_DATA;
						end else begin
							sampleCount <= sampleCount + 1'b1;
						end
					end
					RX_DATA: begin
						// one full bit later is the next center
						if (sampleCount == serialPkg::sampleIndex'(serialPkg::SAMPLES_PER_BIT - 1)) begin
							sampleCount <= '0;
							bitCount <= bitCount + 1'b1;
							if (bitCount == 3'd7) begin
								state <= RX_STOP;
							end
						end else begin
							sampleCount <= sampleCount + 1'b1;
						end
					end
					RX_STOP: begin
						if (sampleCount == serialPkg::sampleIndex'(serialPkg::SAMPLES_PER_BIT - 1)) begin
							// framing error drops the byte
							charValid <= rxLine;
							state <= RX_IDLE;
						end else begin
							sampleCount <= sampleCount + 1'b1;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// lsb first, so new bits enter at the top
	always_ff @(posedge clock) begin
		if (sampleTick && state == RX_DATA &&
			sampleCount == serialPkg::sampleIndex'(serialPkg::SAMPLES_PER_BIT - 1)) begin
			shiftReg <= {rxLine, shiftReg[7:1]};
		end
	end

	assign rxChar = '{data: shiftReg, valid: charValid};

endmodule

/* verilog/serialTransmitter.sv */
`timescale 1ns/1ps

module serialTransmitter (
	input logic clock,
	input logic rst,
	input logic bitTick,
	input logic txLoad,
	input serialPkg::charByte txByte,
	output logic serialOut,
	output logic charSent
);

	// frame still to go out, bit 0 is next on the line
	logic [serialPkg::FRAME_BITS-1:0] frame;
	// bits already driven
	logic [3:0] bitCount;
	logic busy;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			bitCount <= '0;
			serialOut <= 1'b1;
			charSent <= 1'b0;
		end else begin
			charSent <= 1'b0;
			if (!busy) begin
				// load only between frames
				if (txLoad) begin
					busy <= 1'b1;
					bitCount <= '0;
				end
			end else if (bitTick) begin
				if (bitCount == 4'(serialPkg::FRAME_BITS)) begin
					// stop bit has run its full period
					busy <= 1'b0;
					charSent <= 1'b1;
				end else begin
					serialOut <= frame[0];
					bitCount <= bitCount + 1'b1;
				end
			end
		end
	end

	// stop, data, start from msb down
	always_ff @(posedge clock) begin
		if (!busy && txLoad) begin
			frame <= {1'b1, txByte, 1'b0};
		end else if (busy && bitTick) begin
			// shift in idle level behind the frame
			frame <= {1'b1, frame[serialPkg::FRAME_BITS-1:1]};
		end
	end

endmodule

/* verilog/gameTimebase.sv */
`timescale 1ns/1ps

module gameTimebase (
	input logic clock,
	input logic rst,
	input logic timerClear,
	output gamePkg::timebaseSnap snap
);

	// clocks since the last game tick
	gamePkg::tickIndex tickCount;
	// game ticks since reset or clear
	logic [31:0] timeCount;
	logic [15:0] lfsr;
	logic feedback;

	// fibonacci feedback from the tapped bits
	assign feedback = ^(lfsr & gamePkg::LFSR_TAPS);

	always_ff @(posedge clock) begin
		if (rst) begin
			tickCount <= '0;
			timeCount <= '0;
		end else if (timerClear) begin
			// clear beats a tick, and the divider restarts too
			tickCount <= '0;
			timeCount <= '0;
		end else if (tickCount == gamePkg::tickIndex'(gamePkg::CLOCKS_PER_GAME_TICK - 1)) begin
			tickCount <= '0;
			timeCount <= timeCount + 1'b1;
		end else begin
			tickCount <= tickCount + 1'b1;
		end
	end

	// free running, one step per clock
	always_ff @(posedge clock) begin
		if (rst) begin
			lfsr <= gamePkg::LFSR_SEED;
		end else begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	assign snap = '{gameTime: timeCount, randomValue: lfsr};

endmodule

/* verilog/commandResponder.sv */
`timescale 1ns/1ps

module commandResponder (
	input logic clock,
	input logic rst,
	input serialPkg::rxChar rxChar,
	input gamePkg::timebaseSnap snap,
	input logic charSent,
	output serialPkg::charByte txByte,
	output logic txLoad,
	output logic timerClear
);

	typedef enum logic [1:0] {
		RSP_IDLE,
		RSP_LOAD,
		RSP_WAIT
	} rspState;

	rspState state;
	// reply bytes, msb goes out first
	logic [31:0] replyReg;
	// bytes not yet handed to the transmitter
	logic [2:0] bytesLeft;
	logic issueByte;

	// first byte right after the snapshot, later ones on charSent
	assign issueByte = (state == RSP_LOAD) ||
		(state == RSP_WAIT && charSent && bytesLeft != 3'd0);

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= RSP_IDLE;
			bytesLeft <= '0;
			txLoad <= 1'b0;
			timerClear <= 1'b0;
		end else begin
			txLoad <= 1'b0;
			timerClear <= 1'b0;
			case (state)
				RSP_IDLE: begin
					// unknown bytes fall through and are ignored
					if (rxChar.valid) begin
						case (rxChar.data)
							gamePkg::CMD_TIME: begin
								bytesLeft <= 3'd4;
								state <= RSP_LOAD;
							end
							gamePkg::CMD_RANDOM: begin
								bytesLeft <= 3'd2;
								state <= RSP_LOAD;
							end
							gamePkg::CMD_CLEAR: begin
								bytesLeft <= 3'd1;
								timerClear <= 1'b1;
								state <= RSP_LOAD;
							end
							default: state <= RSP_IDLE;
						endcase
					end
				end
				RSP_LOAD: begin
					txLoad <= 1'b1;
					bytesLeft <= bytesLeft - 1'b1;
					state <= RSP_WAIT;
				end
				RSP_WAIT: begin
					// bytes received while busy are dropped here
					if (issueByte) begin
						txLoad <= 1'b1;
						bytesLeft <= bytesLeft - 1'b1;
					end else if (charSent) begin
						// last byte is out
						state <= RSP_IDLE;
					end
				end
				default: state <= RSP_IDLE;
			endcase
		end
	end

	// snapshot on accept, then shift a byte out per load
	always_ff @(posedge clock) begin
		if (state == RSP_IDLE && rxChar.valid) begin
			case (rxChar.data)
				gamePkg::CMD_TIME: replyReg <= snap.gameTime;
				gamePkg::CMD_RANDOM: replyReg <= {snap.randomValue, 16'h0000};
				default: replyReg <= {gamePkg::CMD_CLEAR, 24'h000000};
			endcase
		end else if (issueByte) begin
			replyReg <= {replyReg[23:0], 8'h00};
		end
	end

	always_ff @(posedge clock) begin
		if (issueByte) begin
			txByte <= replyReg[31:24];
		end
	end

endmodule

/* verilog/gameLinkTop.sv */
`timescale 1ns/1ps

module gameLinkTop (
	input logic clock,
	input logic rst,
	input logic serialIn,
	output logic serialOut
);

	// clock enables from the baud divider
	logic sampleTick;
	logic bitTick;

	// receive side into the responder
	serialPkg::rxChar rxData;
	gamePkg::timebaseSnap snap;
	logic timerClear;

	// responder to transmitter
	serialPkg::charByte txByte;
	logic txLoad;
	logic charSent;

	baudTicker i_baudTicker (
		.clock(clock),
		.rst(rst),
		.sampleTick(sampleTick),
		.bitTick(bitTick)
	);

	serialReceiver i_serialReceiver (
		.clock(clock),
		.rst(rst),
		.sampleTick(sampleTick),
		.serialIn(serialIn),
		.rxChar(rxData)
	);

	gameTimebase i_gameTimebase (
		.clock(clock),
		.rst(rst),
		.timerClear(timerClear),
		.snap(snap)
	);

	commandResponder i_commandResponder (
		.clock(clock),
		.rst(rst),
		.rxChar(rxData),
		.snap(snap),
		.charSent(charSent),
		.txByte(txByte),
		.txLoad(txLoad),
		.timerClear(timerClear)
	);

	serialTransmitter i_serialTransmitter (
		.clock(clock),
		.rst(rst),
		.bitTick(bitTick),
		.txLoad(txLoad),
		.txByte(txByte),
		.serialOut(serialOut),
		.charSent(charSent)
	);

endmodule

/* verif/gameLinkTb.sv */
`timescale 1ns/1ps

module gameLinkTb;

	localparam int BIT_CLOCKS = serialPkg::CLOCKS_PER_SAMPLE * serialPkg::SAMPLES_PER_BIT;
	localparam int FRAME_CLOCKS = serialPkg::FRAME_BITS * BIT_CLOCKS;
	// worst reply is 4 frames plus up to 2 bits of bitTick phase
	localparam int REPLY_CLOCKS = 4 * FRAME_CLOCKS + 2 * BIT_CLOCKS;
	localparam int ROUNDS = 3;
	// 7 commands per round and then the framing and overlap tests
	localparam int STEP_CLOCKS = 3 * FRAME_CLOCKS + REPLY_CLOCKS + 64;
	localparam int WATCHDOG_CLOCKS = (ROUNDS * 7 + 3) * STEP_CLOCKS + 1000;

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic serialIn = 1'b1;
	logic serialOut;
	int cycle = 0;
	int resetCycle = 0;
	int errors = 0;
	int checks = 0;
	int startCount = 0;
	integer seed = 32'h156354fd;
	// decoded reply bytes and the cycle each start bit was seen
	serialPkg::charByte rxBytes[$];
	int rxStarts[$];

	gameLinkTop i_gameLinkTop (
		.clock(clock),
		.rst(rst),
		.serialIn(serialIn),
		.serialOut(serialOut)
	);

	initial begin
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// reference lfsr step with the parity of the tapped bits as feedback
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		logic [15:0] taps;
		logic [15:0] bits;
		logic feedback;
		taps = gamePkg::LFSR_TAPS;
		bits = state;
		feedback = 1'b0;
		repeat (16) begin
			if (taps[0]) begin
				feedback = feedback ^ bits[0];
			end
			taps = taps >> 1;
			bits = bits >> 1;
		end
		return {state[14:0], feedback};
	endfunction

	// steps from one state to another inside [lo, hi] or -1 if none
	function automatic int stepsBetween(input logic [15:0] from, input logic [15:0] target,
		input int lo, input int hi);
		logic [15:0] state;
		int n;
		state = from;
		for (n = 0; n <= hi; n++) begin
			if (n >= lo && state == target) begin
				return n;
			end
			state = lfsrStep(state);
		end
		return -1;
	endfunction

	// start, 8 data bits lsb first, stop
	task automatic sendFrame(input serialPkg::charByte code, input logic stopBit);
		logic [9:0] bits;
		bits = {stopBit, code, 1'b0};
		repeat (10) begin
			@(posedge clock);
			serialIn <= bits[0];
			bits = bits >> 1;
			repeat (BIT_CLOCKS - 1) @(posedge clock);
		end
		// back to idle for a low stop bit
		@(posedge clock);
		serialIn <= 1'b1;
	endtask

	// random gap and one command and then count reply bytes msb first
	task automatic command(input serialPkg::charByte code, input int count,
		output logic [31:0] value, output int start);
		int waited;
		repeat ($random(seed) & 63) @(posedge clock);
		sendFrame(code, 1'b1);
		waited = 0;
		while (rxBytes.size() < count && waited < REPLY_CLOCKS + FRAME_CLOCKS) begin
			@(posedge clock);
			waited++;
		end
		value = '0;
		start = cycle;
		if (rxBytes.size() < count) begin
			errors++;
			$display("no %0d-byte reply to command %h arrived on serialOut", count, code);
			rxBytes.delete();
			rxStarts.delete();
		end else begin
			start = rxStarts[0];
			repeat (count) begin
				value = {value[23:0], rxBytes.pop_front()};
				void'(rxStarts.pop_front());
			end
		end
	endtask

	task automatic checkRandom(input logic [15:0] from, input logic [15:0] value,
		input int steps);
		checks++;
		if (value == 16'h0000) begin
			errors++;
			$display("Error at %0t: random value is zero", $time);
		end else if (stepsBetween(from, value, steps - 64, steps + 64) < 0) begin
			errors++;
			$display("Error at %0t: random %h is not %0d +-64 steps after %h",
				$time, value, steps, from);
		end
	endtask

	// elapsed clocks over the game tick rate within plus or minus 2
	task automatic checkTime(input logic [31:0] value, input int elapsed,
		inout logic [31:0] lastTime);
		int expected;
		expected = elapsed / gamePkg::CLOCKS_PER_GAME_TICK;
		checks++;
		if (int'(value) > expected + 2 || int'(value) < expected - 2) begin
			errors++;
			$display("Error at %0t: game time %0d, expected %0d +-2", $time, value, expected);
		end
		if (value < lastTime) begin
			errors++;
			$display("Error at %0t: game time went back from %0d to %0d",
				$time, lastTime, value);
		end
		lastTime = value;
	endtask

	// no new start bit for two frame times
	task automatic expectQuiet(input int priorStarts, input string what);
		repeat (2 * FRAME_CLOCKS) @(posedge clock);
		checks++;
		if (startCount != priorStarts) begin
			errors++;
			$display("serialOut started an unexpected frame after %s", what);
		end
		rxBytes.delete();
		rxStarts.delete();
	endtask

	// one frame from serialOut sampled at each bit center
	task automatic receiveFrame(input int start);
		serialPkg::charByte data;
		// on to the start bit center
		repeat (BIT_CLOCKS / 2 - 1) @(posedge clock);
		if (serialOut !== 1'b0) begin
			errors++;
			$display("start bit on serialOut was too short");
		end else begin
			repeat (8) begin
				repeat (BIT_CLOCKS) @(posedge clock);
				data = {serialOut, data[7:1]};
			end
			repeat (BIT_CLOCKS) @(posedge clock);
			if (serialOut !== 1'b1) begin
				errors++;
				$display("frame on serialOut had a low stop bit");
			end else begin
				rxBytes.push_back(data);
				rxStarts.push_back(start);
			end
		end
	endtask

	// decoder for the DUT transmit line
	initial begin
		forever begin
			@(posedge clock);
			if (!rst && serialOut === 1'b0) begin
				startCount++;
				receiveFrame(cycle);
			end
		end
	end

	initial begin
		logic [31:0] value;
		logic [31:0] lastTime;
		logic [15:0] firstRandom;
		int start;
		int firstStart;
		int timeBase;
		int priorStarts;
		int round;
		serialPkg::charByte junk;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		resetCycle = cycle;
		timeBase = cycle;
		lastTime = '0;
		for (round = 0; round < ROUNDS; round++) begin
			// two random reads on one sequence
			command(gamePkg::CMD_RANDOM, 2, value, start);
			checkRandom(gamePkg::LFSR_SEED, value[15:0], start - resetCycle);
			firstRandom = value[15:0];
			firstStart = start;
			command(gamePkg::CMD_RANDOM, 2, value, start);
			checkRandom(gamePkg::LFSR_SEED, value[15:0], start - resetCycle);
			checkRandom(firstRandom, value[15:0], start - firstStart);
			// timer reads never go back
			command(gamePkg::CMD_TIME, 4, value, start);
			checkTime(value, start - timeBase, lastTime);
			command(gamePkg::CMD_TIME, 4, value, start);
			checkTime(value, start - timeBase, lastTime);
			// clear and the timer counts from zero again
			command(gamePkg::CMD_CLEAR, 1, value, start);
			checks++;
			if (value[7:0] != gamePkg::CMD_CLEAR) begin
				errors++;
				$display("Error at %0t: clear reply %h, expected %h",
					$time, value[7:0], gamePkg::CMD_CLEAR);
			end
			timeBase = start;
			lastTime = '0;
			command(gamePkg::CMD_TIME, 4, value, start);
			checkTime(value, start - timeBase, lastTime);
			// any non-command byte
			junk = 8'($random(seed));
			if (junk == gamePkg::CMD_TIME || junk == gamePkg::CMD_RANDOM ||
				junk == gamePkg::CMD_CLEAR) begin
				junk = junk ^ 8'h80;
			end
			priorStarts = startCount;
			sendFrame(junk, 1'b1);
			expectQuiet(priorStarts, $sformatf("ignored byte %h", junk));
		end
		// framing error
		priorStarts = startCount;
		sendFrame(gamePkg::CMD_RANDOM, 1'b0);
		expectQuiet(priorStarts, "a command with a low stop bit");
		// 'R' arrives while the 'T' reply goes out so only 4 bytes come back
		sendFrame(gamePkg::CMD_TIME, 1'b1);
		command(gamePkg::CMD_RANDOM, 4, value, start);
		checkTime(value, start - timeBase, lastTime);
		expectQuiet(startCount, "a 4-byte reply with a command sent while busy");
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CLOCKS) @(posedge clock);
		$display("watchdog expired before the test sequence finished, errors so far: %0d",
			errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* all.f */
verilog/serialPkg.sv
verilog/gamePkg.sv
verilog/baudTicker.sv
verilog/serialReceiver.sv
verilog/serialTransmitter.sv
verilog/gameTimebase.sv
verilog/commandResponder.sv
verilog/gameLinkTop.sv
verif/gameLinkTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the game link testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

rm -rf "$BUILD" "$LOG"

verilator --binary --timing --top-module gameLinkTb -f all.f -Mdir "$BUILD" -o gameLinkSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD/gameLinkSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
